// ==== isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes the core understands
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_e;

    // funct3 codes, alu group
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    // lw / sw width code
    localparam logic [2:0] f3_word    = 3'b010;

    // addi x0,x0,0
    localparam word_t nop_instr = 32'h0000_0013;

    // add must stay zero, a cleared ctrl word is a bubble
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        opcode_e     opcode;
    } u_fmt_t;

    // one instruction word, viewed per format
    typedef union packed {
        word_t  raw;
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } instr_u;

endpackage

// ==== core_pkg.sv ====
package core_pkg;

    import isa_pkg::*;

    // per-instruction control, all zero means bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;
        alu_op_e alu_op;
    } ctrl_word_t;

    // fetch to decode
    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  valid;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        ctrl_word_t ctrl;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      imm;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        ctrl_word_t ctrl;
        reg_idx_t   rd;
        word_t      alu_out;
        word_t      store_data;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        word_t    result;
    } mem_wb_t;

    // register file write port, also the late forwarding source
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    // bus request, held until the matching response
    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // rdata only meaningful for reads
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_rsp_t;

endpackage

// ==== fetch_unit.sv ====
module fetch_unit #(
    parameter isa_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               pipe_hold_i,
    input  logic               load_use_stall_i,
    input  core_pkg::mem_rsp_t ifetch_rsp_i,
    output core_pkg::mem_req_t ifetch_req_o,
    output core_pkg::if_id_t   if_id_o
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t  pc_q;
    logic   run_q;
    logic   advance;
    if_id_t if_id_q;

    // IF/ID moves only when nothing holds and decode is not stalled
    assign advance = !pipe_hold_i && !load_use_stall_i;

    // read-only client, address is always the current pc
    always_comb begin
        ifetch_req_o.valid = run_q && !load_use_stall_i;
        ifetch_req_o.write = 1'b0;
        ifetch_req_o.addr  = pc_q;
        ifetch_req_o.wdata = '0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q          <= reset_pc;
            run_q         <= 1'b0;
            if_id_q.valid <= 1'b0;
        end else begin
            // start requesting once out of reset
            run_q <= 1'b1;
            if (advance) begin
                // no response means decode took the old word, leave a hole
                if_id_q.valid <= ifetch_rsp_i.valid;
                if (ifetch_rsp_i.valid) begin
                    if_id_q.pc    <= pc_q;
                    if_id_q.instr <= ifetch_rsp_i.rdata;
                    pc_q          <= pc_q + 32'd4;
                end
            end
        end
    end

    assign if_id_o = if_id_q;

endmodule

// ==== decode_stage.sv ====
module decode_stage (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             pipe_hold_i,
    input  core_pkg::if_id_t if_id_i,
    input  core_pkg::wb_t    wb_i,
    output core_pkg::id_ex_t id_ex_o,
    output logic             load_use_stall_o
);
    import isa_pkg::*;
    import core_pkg::*;

    instr_u     instr;
    ctrl_word_t ctrl;
    logic       use_rs1;
    logic       use_rs2;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;
    word_t      rs1_val;
    word_t      rs2_val;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;
    word_t      rf_q [32];

    // alt picks sub / sra (instr bit 30)
    function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        op = alu_add;
        case (funct3)
            f3_add_sub: op = alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            f3_and:     op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        instr   = if_id_i.instr;
        ctrl    = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        imm     = '0;
        case (instr.r.opcode)
            opc_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(instr.r.funct3, instr.r.funct7[5]);
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            opc_op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                // addi has no sub form, only shifts look at bit 30
                ctrl.alu_op    = alu_decode(instr.i.funct3,
                                            instr.i.funct3 == f3_srl_sra && instr.r.funct7[5]);
                use_rs1        = 1'b1;
                imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            opc_lui: begin
                // x0 + upper immediate, rs1 stays 0
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                imm            = {instr.u.imm, 12'b0};
            end
            opc_load: begin
                if (instr.i.funct3 == f3_word) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.use_imm   = 1'b1;
                    use_rs1        = 1'b1;
                    imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
                end
            end
            opc_store: begin
                if (instr.s.funct3 == f3_word) begin
                    ctrl.mem_write = 1'b1;
                    ctrl.use_imm   = 1'b1;
                    use_rs1        = 1'b1;
                    use_rs2        = 1'b1;
                    imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                end
            end
            // anything else falls out as a bubble
            default: ;
        endcase
        // empty slot or plain nop, nothing to carry
        if (!if_id_i.valid || instr.raw == nop_instr) begin
            ctrl    = '0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    // unused sources read as x0, keeps hazard compares honest
    assign rs1 = use_rs1 ? instr.r.rs1 : '0;
    assign rs2 = use_rs2 ? instr.r.rs2 : '0;

    // register read with write-through from writeback
    always_comb begin
        rs1_val = rf_q[rs1];
        rs2_val = rf_q[rs2];
        if (wb_i.we && wb_i.rd == rs1) begin
            rs1_val = wb_i.data;
        end
        if (wb_i.we && wb_i.rd == rs2) begin
            rs2_val = wb_i.data;
        end
        if (rs1 == '0) begin
            rs1_val = '0;
        end
        if (rs2 == '0) begin
            rs2_val = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_i.we && wb_i.rd != '0) begin
            rf_q[wb_i.rd] <= wb_i.data;
        end
    end

    // load in EX whose result this instruction needs
    assign load_use_stall_o = id_ex_q.ctrl.mem_read && id_ex_q.rd != '0 &&
                              (id_ex_q.rd == rs1 || id_ex_q.rd == rs2);

    always_comb begin
        id_ex_d.ctrl    = load_use_stall_o ? '0 : ctrl;
        id_ex_d.rs1     = rs1;
        id_ex_d.rs2     = rs2;
        id_ex_d.rd      = instr.r.rd;
        id_ex_d.rs1_val = rs1_val;
        id_ex_d.rs2_val = rs2_val;
        id_ex_d.imm     = imm;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_q.ctrl <= '0;
        end else if (!pipe_hold_i) begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

// ==== execute_stage.sv ====
module execute_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              pipe_hold_i,
    input  core_pkg::id_ex_t  id_ex_i,
    output core_pkg::ex_mem_t ex_mem_o,
    input  core_pkg::wb_t     wb_i
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t   op_a;
    word_t   op_b;
    word_t   rs2_fwd;
    word_t   alu_out;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;

    // newest producer wins, a load in EX/MEM has no value yet
    function automatic word_t forward(input reg_idx_t src, input word_t reg_val,
                                      input ex_mem_t ex_mem, input wb_t wb);
        word_t val;
        val = reg_val;
        if (wb.we && wb.rd != '0 && wb.rd == src) begin
            val = wb.data;
        end
        if (ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read &&
            ex_mem.rd != '0 && ex_mem.rd == src) begin
            val = ex_mem.alu_out;
        end
        return val;
    endfunction

    always_comb begin
        op_a    = forward(id_ex_i.rs1, id_ex_i.rs1_val, ex_mem_q, wb_i);
        rs2_fwd = forward(id_ex_i.rs2, id_ex_i.rs2_val, ex_mem_q, wb_i);
        op_b    = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_fwd;
    end

    // shift amounts from low five bits only
    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            alu_add:  alu_out = op_a + op_b;
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << op_b[4:0];
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> op_b[4:0];
            alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
            alu_or:   alu_out = op_a | op_b;
            alu_and:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    // store data is the forwarded rs2, not the immediate
    always_comb begin
        ex_mem_d.ctrl       = id_ex_i.ctrl;
        ex_mem_d.rd         = id_ex_i.rd;
        ex_mem_d.alu_out    = alu_out;
        ex_mem_d.store_data = rs2_fwd;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_mem_q.ctrl <= '0;
        end else if (!pipe_hold_i) begin
            ex_mem_q <= ex_mem_d;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

// ==== mem_access.sv ====
module mem_access (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               pipe_hold_i,
    input  core_pkg::ex_mem_t  ex_mem_i,
    input  core_pkg::mem_rsp_t data_rsp_i,
    output core_pkg::mem_req_t data_req_o,
    output core_pkg::wb_t      wb_o
);
    import isa_pkg::*;
    import core_pkg::*;

    logic    access;
    logic    done_q;
    word_t   rdata_q;
    word_t   load_data;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    assign access = ex_mem_i.ctrl.mem_read || ex_mem_i.ctrl.mem_write;

    // request stays up until answered, then drops while the stage waits
    always_comb begin
        data_req_o.valid = access && !done_q;
        data_req_o.write = ex_mem_i.ctrl.mem_write;
        data_req_o.addr  = ex_mem_i.alu_out;
        data_req_o.wdata = ex_mem_i.store_data;
    end

    // answered but the pipe is still held by fetch
    always_ff @(posedge clk) begin
        if (reset_i || !pipe_hold_i) begin
            done_q <= 1'b0;
        end else if (data_rsp_i.valid) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_rsp_i.valid) begin
            rdata_q <= data_rsp_i.rdata;
        end
    end

    // early answer parked in rdata_q, otherwise straight from the bus
    assign load_data = done_q ? rdata_q : data_rsp_i.rdata;

    always_comb begin
        mem_wb_d.reg_write = ex_mem_i.ctrl.reg_write;
        mem_wb_d.rd        = ex_mem_i.rd;
        mem_wb_d.result    = ex_mem_i.ctrl.mem_read ? load_data : ex_mem_i.alu_out;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_wb_q.reg_write <= 1'b0;
        end else if (!pipe_hold_i) begin
            mem_wb_q <= mem_wb_d;
        end
    end

    assign wb_o = '{we: mem_wb_q.reg_write, rd: mem_wb_q.rd, data: mem_wb_q.result};

endmodule

// ==== mem_arbiter.sv ====
module mem_arbiter (
    input  logic               clk,
    input  logic               reset_i,
    input  core_pkg::mem_req_t ifetch_req_i,
    input  core_pkg::mem_req_t data_req_i,
    input  core_pkg::mem_rsp_t mem_rsp_i,
    output core_pkg::mem_req_t mem_req_o,
    output core_pkg::mem_rsp_t ifetch_rsp_o,
    output core_pkg::mem_rsp_t data_rsp_o,
    output logic               pipe_hold_o
);

    logic busy_q;
    logic owner_data_q;
    logic grant_data;

    // idle bus goes to data first, busy bus stays with its owner
    assign grant_data = busy_q ? owner_data_q : data_req_i.valid;
    assign mem_req_o  = grant_data ? data_req_i : ifetch_req_i;

    // one access in flight, ends on the response
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q       <= 1'b0;
            owner_data_q <= 1'b0;
        end else if (busy_q) begin
            if (mem_rsp_i.valid) begin
                busy_q <= 1'b0;
            end
        end else if (mem_req_o.valid) begin
            busy_q       <= 1'b1;
            owner_data_q <= grant_data;
        end
    end

    // response only to whoever holds the bus
    always_comb begin
        ifetch_rsp_o       = mem_rsp_i;
        data_rsp_o         = mem_rsp_i;
        ifetch_rsp_o.valid = mem_rsp_i.valid && busy_q && !owner_data_q;
        data_rsp_o.valid   = mem_rsp_i.valid && busy_q && owner_data_q;
    end

    // Every stage freezes while any client still waits for its answer.
    assign pipe_hold_o = (ifetch_req_i.valid && !ifetch_rsp_o.valid) ||
                         (data_req_i.valid && !data_rsp_o.valid);

endmodule

// ==== rv32i_core.sv ====
module rv32i_core #(
    parameter isa_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               reset_i,
    output core_pkg::mem_req_t mem_req_o,
    input  core_pkg::mem_rsp_t mem_rsp_i
);
    import core_pkg::*;

    mem_req_t ifetch_req;
    mem_req_t data_req;
    mem_rsp_t ifetch_rsp;
    mem_rsp_t data_rsp;
    logic     pipe_hold;
    logic     load_use_stall;
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    wb_t      wb;

    // fetch and data share the single external port
    mem_arbiter mem_arbiter_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .ifetch_req_i (ifetch_req),
        .data_req_i   (data_req),
        .mem_rsp_i    (mem_rsp_i),
        .mem_req_o    (mem_req_o),
        .ifetch_rsp_o (ifetch_rsp),
        .data_rsp_o   (data_rsp),
        .pipe_hold_o  (pipe_hold)
    );

    fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_unit_inst (
        .clk              (clk),
        .reset_i          (reset_i),
        .pipe_hold_i      (pipe_hold),
        .load_use_stall_i (load_use_stall),
        .ifetch_rsp_i     (ifetch_rsp),
        .ifetch_req_o     (ifetch_req),
        .if_id_o          (if_id)
    );

    // writeback feeds the register file here and forwarding in execute
    decode_stage decode_stage_inst (
        .clk              (clk),
        .reset_i          (reset_i),
        .pipe_hold_i      (pipe_hold),
        .if_id_i          (if_id),
        .wb_i             (wb),
        .id_ex_o          (id_ex),
        .load_use_stall_o (load_use_stall)
    );

    execute_stage execute_stage_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .pipe_hold_i (pipe_hold),
        .id_ex_i     (id_ex),
        .ex_mem_o    (ex_mem),
        .wb_i        (wb)
    );

    mem_access mem_access_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .pipe_hold_i (pipe_hold),
        .ex_mem_i    (ex_mem),
        .data_rsp_i  (data_rsp),
        .data_req_o  (data_req),
        .wb_o        (wb)
    );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int half_period = 4,
    parameter int reset_cycles = 10
) (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period with the defaults
    initial clk_o = 1'b0;
    always #(half_period) clk_o = ~clk_o;

    // reset drops on a rising edge, like every other input
    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== tb_memory.sv ====
module tb_memory #(
    parameter int             words      = 4096,
    parameter isa_pkg::word_t prog_limit = 32'h0000_1000,
    parameter logic [31:0]    seed       = 32'h58cd_43f5
) (
    input  logic               clk,
    input  logic               reset_i,
    input  core_pkg::mem_req_t mem_req_i,
    output core_pkg::mem_rsp_t mem_rsp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import core_pkg::*;

    // program image below prog_limit, data store above
    word_t       rom [words];
    logic        rom_set [words] = '{default: 1'b0};
    word_t       ram [words];
    logic [31:0] lfsr_q = seed;
    logic        busy_q = 1'b0;
    logic [2:0]  wait_q = '0;
    mem_rsp_t    rsp_q = '0;

    // taps 32 22 2 1, new bit enters at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // program loader, called before reset is released
    task automatic load_word(input word_t addr, input word_t data);
        rom[addr[13:2]]     = data;
        rom_set[addr[13:2]] = 1'b1;
    endtask

    // outside the program a fetch sees a nop
    function automatic word_t read_word(input word_t addr);
        if (addr < prog_limit) begin
            return rom_set[addr[13:2]] ? rom[addr[13:2]] : nop_instr;
        end
        return ram[addr[13:2]];
    endfunction

    always @(posedge clk) begin
        logic [31:0] s1;
        logic [31:0] s2;
        rsp_q.valid <= 1'b0;
        if (reset_i) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            if (wait_q <= 3'd1) begin
                busy_q      <= 1'b0;
                rsp_q.valid <= 1'b1;
                if (mem_req_i.write) begin
                    ram[mem_req_i.addr[13:2]] <= mem_req_i.wdata;
                    rsp_q.rdata               <= '0;
                end else begin
                    rsp_q.rdata <= read_word(mem_req_i.addr);
                end
            end else begin
                wait_q <= wait_q - 3'd1;
            end
        end else if (mem_req_i.valid && !rsp_q.valid) begin
            // two bits give 1 to 4 cycles
            s1     = lfsr_next(lfsr_q);
            s2     = lfsr_next(s1);
            lfsr_q <= s2;
            wait_q <= {1'b0, s2[0], s1[0]} + 3'd1;
            busy_q <= 1'b1;
        end
    end

    assign mem_rsp_o = rsp_q;

endmodule

// ==== tb_rv32i_core.sv ====
module tb_rv32i_core;
    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import core_pkg::*;

    typedef enum logic [4:0] {
        k_add, k_sub, k_and, k_or, k_xor, k_slt, k_sltu, k_sll, k_srl, k_sra,
        k_addi, k_slti, k_sltiu, k_xori, k_ori, k_andi, k_slli, k_srli, k_srai,
        k_lui, k_x0, k_load_use
    } kind_e;

    typedef struct packed {
        kind_e kind;
        word_t a;
        word_t b;
        word_t exp;
    } stim_t;

    localparam word_t reset_pc     = 32'h0000_0100;
    localparam word_t store_base   = 32'h0000_1000;
    localparam word_t scratch_base = 32'h0000_2000;
    localparam int    num_stim     = 23;
    localparam int    max_cycles   = 5000;

    // op, a, b, result by the RV32I rule
    stim_t stim [num_stim] = '{
        '{k_add,      32'h0000_1234, 32'h0000_0f00, 32'h0000_2134},
        '{k_sub,      32'h0000_0005, 32'h0000_0007, 32'hffff_fffe},
        '{k_and,      32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200},
        '{k_or,       32'hf000_000f, 32'h0f00_00f0, 32'hff00_00ff},
        '{k_xor,      32'haaaa_5555, 32'hffff_0000, 32'h5555_5555},
        '{k_slt,      32'hffff_ffff, 32'h0000_0001, 32'h0000_0001},
        '{k_sltu,     32'hffff_ffff, 32'h0000_0001, 32'h0000_0000},
        '{k_sll,      32'h0000_0003, 32'h0000_0024, 32'h0000_0030},
        '{k_srl,      32'h8000_0000, 32'h0000_001f, 32'h0000_0001},
        '{k_sra,      32'h8000_0000, 32'h0000_0004, 32'hf800_0000},
        '{k_addi,     32'h0000_0100, 32'hffff_ffff, 32'h0000_00ff},
        '{k_slti,     32'hffff_fff0, 32'h0000_0005, 32'h0000_0001},
        '{k_sltiu,    32'h0000_0005, 32'hffff_f800, 32'h0000_0001},
        '{k_xori,     32'h1234_5678, 32'hffff_ffff, 32'hedcb_a987},
        '{k_ori,      32'h1200_0000, 32'h0000_0345, 32'h1200_0345},
        '{k_andi,     32'hffff_ffff, 32'h0000_07f0, 32'h0000_07f0},
        '{k_slli,     32'h0000_0001, 32'h0000_001f, 32'h8000_0000},
        '{k_srli,     32'hf000_0000, 32'h0000_0004, 32'h0f00_0000},
        '{k_srai,     32'hf000_0000, 32'h0000_0004, 32'hff00_0000},
        '{k_lui,      32'h0000_0000, 32'habcd_e000, 32'habcd_e000},
        '{k_x0,       32'h0000_0005, 32'h0000_0006, 32'h0000_0000},
        '{k_load_use, 32'h0000_0010, 32'h1234_5678, 32'h1234_5688},
        '{k_load_use, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000}
    };

    logic     clk;
    logic     reset_i;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    word_t    prog [$];
    word_t    exp_addr_q [$];
    word_t    exp_data_q [$];
    word_t    exp_fetch;
    int       store_errs;
    int       fetch_errs;
    int       timeout_errs;

    tb_clock_gen clock_gen_inst (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    rv32i_core #(
        .reset_pc (reset_pc)
    ) rv32i_core_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    tb_memory memory_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    // instruction encoders in ISA manual field order
    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], opc_store};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, opc_lui};
    endfunction

    function automatic logic [2:0] kind_f3(input kind_e k);
        case (k)
            k_sll, k_slli:          return f3_sll;
            k_slt, k_slti:          return f3_slt;
            k_sltu, k_sltiu:        return f3_sltu;
            k_xor, k_xori:          return f3_xor;
            k_srl, k_sra, k_srli, k_srai: return f3_srl_sra;
            k_or, k_ori:            return f3_or;
            k_and, k_andi:          return f3_and;
            default:                return f3_add_sub;
        endcase
    endfunction

    // lui + addi with the upper part rounded up for a negative low half
    task automatic build_const(input reg_idx_t rd, input word_t val);
        word_t hi;
        hi = val + 32'h0000_0800;
        prog.push_back(enc_u(hi[31:12], rd));
        prog.push_back(enc_i(val[11:0], rd, f3_add_sub, rd, opc_op_imm));
    endtask

    task automatic assemble_program();
        word_t       off_w;
        logic [11:0] off;
        logic [6:0]  alt;
        reg_idx_t    src;
        // x5 and x6 hold the two store bases
        prog.push_back(enc_u(20'h00001, 5'd5));
        prog.push_back(enc_u(20'h00002, 5'd6));
        for (int i = 0; i < num_stim; i++) begin
            off_w = word_t'(4 * i);
            off   = off_w[11:0];
            alt   = (stim[i].kind inside {k_sub, k_sra, k_srai}) ? 7'b0100000 : 7'b0;
            src   = 5'd3;
            build_const(5'd1, stim[i].a);
            build_const(5'd2, stim[i].b);
            case (stim[i].kind)
                k_add, k_sub, k_and, k_or, k_xor, k_slt, k_sltu, k_sll, k_srl, k_sra:
                    prog.push_back(enc_r(alt, 5'd2, 5'd1, kind_f3(stim[i].kind), 5'd3));
                k_slli, k_srli, k_srai:
                    prog.push_back(enc_i({alt, stim[i].b[4:0]}, 5'd1,
                                         kind_f3(stim[i].kind), 5'd3, opc_op_imm));
                k_lui:
                    prog.push_back(enc_u(stim[i].b[31:12], 5'd3));
                k_x0: begin
                    // result is dropped and x0 gets stored
                    prog.push_back(enc_r(7'b0, 5'd2, 5'd1, f3_add_sub, 5'd0));
                    src = 5'd0;
                end
                k_load_use: begin
                    prog.push_back(enc_s(off, 5'd2, 5'd6));
                    exp_addr_q.push_back(scratch_base + off_w);
                    exp_data_q.push_back(stim[i].b);
                    // add right behind the load
                    prog.push_back(enc_i(off, 5'd6, f3_word, 5'd4, opc_load));
                    prog.push_back(enc_r(7'b0, 5'd1, 5'd4, f3_add_sub, 5'd3));
                end
                default:
                    prog.push_back(enc_i(stim[i].b[11:0], 5'd1,
                                         kind_f3(stim[i].kind), 5'd3, opc_op_imm));
            endcase
            prog.push_back(enc_s(off, src, 5'd5));
            exp_addr_q.push_back(store_base + off_w);
            exp_data_q.push_back(stim[i].exp);
        end
        foreach (prog[j]) begin
            memory_inst.load_word(reset_pc + word_t'(4 * j), prog[j]);
        end
    endtask

    task automatic check_store(input core_pkg::mem_req_t got, input isa_pkg::word_t exp_addr,
                               input isa_pkg::word_t exp_data);
        if (got.valid !== 1'b1 || got.addr !== exp_addr || got.wdata !== exp_data) begin
            store_errs++;
            $display("Error at %0t: store %h <- %h valid %b, expected %h <- %h",
                     $time, got.addr, got.wdata, got.valid, exp_addr, exp_data);
        end
    endtask

    task automatic check_fetch(input core_pkg::mem_req_t got, input isa_pkg::word_t exp_addr);
        if (got.valid !== 1'b1 || got.write !== 1'b0 || got.addr !== exp_addr) begin
            fetch_errs++;
            $display("Error at %0t: fetch from %h valid %b, expected %h",
                     $time, got.addr, got.valid, exp_addr);
        end
    endtask

    // each response closes one bus access
    task automatic observe_bus();
        if (mem_rsp.valid) begin
            if (mem_req.write) begin
                if (exp_addr_q.size() == 0) begin
                    store_errs++;
                    $display("Error at %0t: extra store %h <- %h",
                             $time, mem_req.addr, mem_req.wdata);
                end else begin
                    check_store(mem_req, exp_addr_q.pop_front(), exp_data_q.pop_front());
                end
            end else if (mem_req.addr < store_base) begin
                check_fetch(mem_req, exp_fetch);
                exp_fetch = exp_fetch + 32'd4;
            end
        end
    endtask

    initial begin
        int cycles;
        store_errs   = 0;
        fetch_errs   = 0;
        timeout_errs = 0;
        exp_fetch    = reset_pc;
        assemble_program();
        cycles = 0;
        while (reset_i !== 1'b0 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (reset_i !== 1'b0) begin
            timeout_errs++;
            $display("reset was never released");
        end
        cycles = 0;
        while (exp_addr_q.size() > 0 && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
            observe_bus();
        end
        if (exp_addr_q.size() > 0) begin
            timeout_errs++;
            $display("the stores did not all appear in time, %0d still missing",
                     exp_addr_q.size());
        end else begin
            // short tail to catch a repeated store
            cycles = 0;
            while (cycles < 100) begin
                @(negedge clk);
                cycles++;
                observe_bus();
            end
        end
        $display("store errors %0d, fetch errors %0d, timeout errors %0d",
                 store_errs, fetch_errs, timeout_errs);
        if (store_errs + fetch_errs + timeout_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rv32i_core.f ====
isa_pkg.sv
core_pkg.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
mem_access.sv
mem_arbiter.sv
rv32i_core.sv
tb_clock_gen.sv
tb_memory.sv
tb_rv32i_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_rv32i_core
FILELIST   ?= rv32i_core.f
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module rv32i_core -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
